// File: trap_ctrl_top.f
logic/trap_pkg.sv
logic/clint_pkg.sv
logic/clint_timer.sv
logic/trap_select.sv
logic/trap_fsm.sv
logic/mcsr_file.sv
logic/trap_ctrl_top.sv
tests/trap_ctrl_checker.sv
tests/trap_ctrl_tb.sv

// File: Bender.yml
package:
  name: trap_ctrl

sources:
  - logic/trap_pkg.sv
  - logic/clint_pkg.sv
  - logic/clint_timer.sv
  - logic/trap_select.sv
  - logic/trap_fsm.sv
  - logic/mcsr_file.sv
  - logic/trap_ctrl_top.sv
  - target: simulation
    files:
      - tests/trap_ctrl_checker.sv
      - tests/trap_ctrl_tb.sv

// File: tests/trap_ctrl_tb.sv
// inputs change 1 ns after the rising edge; mtimecmp is only ever programmed to 0 or all ones
`timescale 1ns/1ps

module trap_ctrl_tb;

    localparam int TIMEOUT = 50; // cycles per wait

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      req_valid;
    trap_pkg::trap_req_t       req;
    logic                      req_ready;
    logic                      hold;
    logic                      ext_irq;
    logic                      cfg_valid;
    clint_pkg::cfg_wr_t        cfg;
    logic                      redirect_valid;
    logic [trap_pkg::XLEN-1:0] redirect_pc;
    trap_pkg::csr_view_t       csr_view;

    logic [31:0]               lfsr_q;
    trap_pkg::csr_view_t       model;    // expected CSR contents
    logic                      tmr_line; // expected timer and software lines
    logic                      sw_line;

    trap_ctrl_top trap_ctrl_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .req_ready_o     (req_ready),
        .hold_i          (hold),
        .ext_irq_i       (ext_irq),
        .cfg_valid_i     (cfg_valid),
        .cfg_i           (cfg),
        .redirect_valid_o(redirect_valid),
        .redirect_pc_o   (redirect_pc),
        .csr_o           (csr_view)
    );

    always #4 clk = ~clk;

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    function automatic trap_pkg::trap_req_t rand_req(input trap_pkg::exc_e kind);
        trap_pkg::trap_req_t r;
        r.pc      = rand_bits(32);
        r.next_pc = rand_bits(32);
        r.inst    = rand_bits(32);
        r.kind    = kind;
        return r;
    endfunction

    // returns 1 when the request traps and fills in the expected CSRs and target
    function automatic logic ref_trap(
        input  trap_pkg::trap_req_t r,
        input  logic [2:0]          lines, // ext, timer, soft
        input  trap_pkg::csr_view_t cur,
        output trap_pkg::csr_view_t nxt,
        output logic [31:0]         target
    );
        logic [2:0] en;
        logic       is_int;
        en     = lines & {cur.mie[11], cur.mie[7], cur.mie[3]} & {3{cur.mstatus[3]}};
        nxt    = cur;
        target = '0;
        is_int = 1'b0;
        case (r.kind)
            trap_pkg::MRET: begin
                target         = cur.mepc;
                nxt.mstatus[3] = cur.mstatus[7];
                nxt.mstatus[7] = 1'b1;
                return 1'b1;
            end
            trap_pkg::NONE: begin
                if (en == 3'b000) return 1'b0;
                is_int     = 1'b1;
                nxt.mcause = en[2] ? 32'h8000_000b : (en[1] ? 32'h8000_0007 : 32'h8000_0003);
                nxt.mtval  = '0;
            end
            trap_pkg::ECALL: begin
                nxt.mcause = 32'd11;
                nxt.mtval  = '0;
            end
            trap_pkg::EBREAK: begin
                nxt.mcause = 32'd3;
                nxt.mtval  = '0;
            end
            trap_pkg::ILLEGAL: begin
                nxt.mcause = 32'd2;
                nxt.mtval  = r.inst;
            end
            trap_pkg::MIS_FETCH: begin
                nxt.mcause = 32'd0;
                nxt.mtval  = r.pc;
            end
            trap_pkg::MIS_LOAD: begin
                nxt.mcause = 32'd4;
                nxt.mtval  = r.next_pc; // data address
            end
            default: begin
                nxt.mcause = 32'd6;
                nxt.mtval  = r.next_pc;
            end
        endcase
        nxt.mepc       = is_int ? r.next_pc : r.pc;
        nxt.mstatus[7] = cur.mstatus[3];
        nxt.mstatus[3] = 1'b0;
        target         = {cur.mtvec[31:2], 2'b00};
        if (is_int && cur.mtvec[0]) target = target + 4 * nxt.mcause[30:0];
        return 1'b1;
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            abort("value mismatch");
        end
    endtask

    task automatic check_view(input string name, input trap_pkg::csr_view_t exp);
        check({name, " mstatus"}, exp.mstatus, csr_view.mstatus);
        check({name, " mie"}, exp.mie, csr_view.mie);
        check({name, " mtvec"}, exp.mtvec, csr_view.mtvec);
        check({name, " mepc"}, exp.mepc, csr_view.mepc);
        check({name, " mcause"}, exp.mcause, csr_view.mcause);
        check({name, " mtval"}, exp.mtval, csr_view.mtval);
    endtask

    task automatic cfg_write(input logic [11:0] addr, input logic [31:0] data);
        cfg.addr  = addr;
        cfg.data  = data;
        cfg_valid = 1'b1;
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
        case (addr)
            clint_pkg::MTIMECMP_ADDR: tmr_line = (data == 32'd0);
            clint_pkg::MSIP_ADDR:     sw_line  = data[0];
            trap_pkg::CSR_MSTATUS:    model.mstatus = data;
            trap_pkg::CSR_MIE:        model.mie = data;
            trap_pkg::CSR_MTVEC:      model.mtvec = data;
            default: ;
        endcase
        if (addr == clint_pkg::MTIMECMP_ADDR) begin
            @(posedge clk); // compare result is registered
            #1;
        end
    endtask

    task automatic wait_redirect(input string name);
        int n;
        n = 0;
        while (!redirect_valid && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!redirect_valid) abort({name, ": redirect never came"});
    endtask

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (!req_ready && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!req_ready) abort({name, ": req_ready_o stayed low"});
    endtask

    // offers one request, optionally holding the FSM in PENDING, and compares the outcome
    task automatic run_req(input trap_pkg::trap_req_t r, input int hold_cycles, input string name);
        trap_pkg::csr_view_t nxt;
        logic [31:0]         target;
        logic                takes;
        takes = ref_trap(r, {ext_irq, tmr_line, sw_line}, model, nxt, target);
        wait_ready(name);
        hold      = (hold_cycles > 0);
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (takes) begin
            for (int n = 0; n < hold_cycles; n++) begin
                check({name, " ready held low"}, 0, req_ready);
                check({name, " redirect under hold"}, 0, redirect_valid);
                @(posedge clk);
                #1;
            end
            hold = 1'b0;
            wait_redirect(name);
            check({name, " target"}, target, redirect_pc);
            wait_ready(name);
            check_view(name, nxt);
            model = nxt;
        end else begin
            hold = 1'b0;
            check({name, " ready"}, 1, req_ready);
            for (int n = 0; n < 3; n++) begin
                check({name, " no redirect"}, 0, redirect_valid);
                @(posedge clk);
                #1;
            end
            check_view(name, model);
        end
    endtask

    // protocol assertions in the bound checker
    always @(posedge clk) begin
        if (trap_ctrl_top_i.trap_ctrl_checker_i.assert_failed) begin
            abort("a protocol assertion in the bound checker failed");
        end
    end

    initial begin
        logic [31:0] k;
        int          h;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        hold      = 1'b0;
        ext_irq   = 1'b0;
        cfg_valid = 1'b0;
        cfg       = '0;
        lfsr_q    = 32'hd963_61ec;
        model     = '0;
        tmr_line  = 1'b0;
        sw_line   = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("reset ready", 1, req_ready);
        check("reset redirect", 0, redirect_valid);
        check_view("reset", model);

        for (int i = 0; i < 3; i++) run_req(rand_req(trap_pkg::NONE), 0, "pass_masked");

        for (int i = 0; i < 12; i++) begin
            cfg_write(trap_pkg::CSR_MTVEC, rand_bits(32));
            cfg_write(trap_pkg::CSR_MSTATUS, rand_bits(1) << 3); // random MIE
            k = rand_bits(3) % 6 + 1;
            run_req(rand_req(trap_pkg::exc_e'(k[2:0])), 0, "exception");
        end

        // timer interrupt in vectored mode followed by mret
        cfg_write(clint_pkg::MTIMECMP_ADDR, 32'd0);
        cfg_write(trap_pkg::CSR_MTVEC, 32'h0000_2001);
        cfg_write(trap_pkg::CSR_MIE, 32'h0000_0080);
        cfg_write(trap_pkg::CSR_MSTATUS, 32'h0000_0008);
        run_req(rand_req(trap_pkg::NONE), 0, "timer_irq");
        run_req(rand_req(trap_pkg::MRET), 0, "mret");

        // all three lines raised to check ext over timer over soft
        cfg_write(trap_pkg::CSR_MIE, 32'h0000_0888);
        cfg_write(clint_pkg::MSIP_ADDR, 32'd1);
        ext_irq = 1'b1;
        run_req(rand_req(trap_pkg::NONE), 0, "ext_irq");
        run_req(rand_req(trap_pkg::MRET), 0, "mret_ext");
        ext_irq = 1'b0;
        run_req(rand_req(trap_pkg::NONE), 0, "timer_over_soft");
        run_req(rand_req(trap_pkg::MRET), 0, "mret_timer");
        cfg_write(clint_pkg::MTIMECMP_ADDR, 32'hffff_ffff);
        run_req(rand_req(trap_pkg::NONE), 0, "soft_irq");
        run_req(rand_req(trap_pkg::MRET), 0, "mret_soft");

        ext_irq = 1'b1;
        cfg_write(trap_pkg::CSR_MSTATUS, 32'd0);
        run_req(rand_req(trap_pkg::NONE), 0, "mask_global");
        cfg_write(trap_pkg::CSR_MSTATUS, 32'h0000_0008);
        cfg_write(trap_pkg::CSR_MIE, 32'd0);
        run_req(rand_req(trap_pkg::NONE), 0, "mask_mie");

        // back-pressure; ecall also beats the pending external line
        cfg_write(trap_pkg::CSR_MIE, 32'h0000_0800);
        for (int i = 0; i < 3; i++) begin
            cfg_write(trap_pkg::CSR_MSTATUS, 32'h0000_0008);
            h = 1 + rand_bits(3);
            run_req(rand_req(trap_pkg::ECALL), h, "hold_exc");
            cfg_write(trap_pkg::CSR_MSTATUS, 32'h0000_0008);
            h = 1 + rand_bits(3);
            run_req(rand_req(trap_pkg::NONE), h, "hold_irq");
        end

        @(posedge clk);
        #1;
        if (trap_ctrl_top_i.trap_ctrl_checker_i.assert_failed) begin
            abort("a protocol assertion in the bound checker failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: tests/trap_ctrl_checker.sv
// sees the top-level handshake plus the internal take strobe; checks nothing while in reset
`timescale 1ns/1ps

module trap_ctrl_checker (
    input logic clk,
    input logic rst_n,
    input logic req_valid_i,
    input logic req_ready_i,
    input logic take_i,
    input logic hold_i,
    input logic redirect_valid_i
);

    logic in_trap_q; // accepted trap still waiting for its redirect
    logic assert_failed = 1'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_trap_q <= 1'b0;
        end else if (req_valid_i && req_ready_i && take_i) begin
            in_trap_q <= 1'b1;
        end else if (redirect_valid_i) begin
            in_trap_q <= 1'b0;
        end
    end

    a_redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid_i |=> !redirect_valid_i)
        else begin
            assert_failed = 1'b1;
            $error("redirect_valid_o high for two cycles in a row");
        end

    a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        in_trap_q |-> !req_ready_i)
        else begin
            assert_failed = 1'b1;
            $error("req_ready_o high before the redirect of an accepted trap");
        end

    a_hold_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        hold_i |=> !redirect_valid_i)
        else begin
            assert_failed = 1'b1;
            $error("redirect issued while hold_i was high");
        end

endmodule

bind trap_ctrl_top trap_ctrl_checker trap_ctrl_checker_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid_i),
    .req_ready_i     (req_ready_o),
    .take_i          (take),
    .hold_i          (hold_i),
    .redirect_valid_i(redirect_valid_o)
);

// File: logic/trap_ctrl_top.sv
// single hart, machine mode; a request is accepted only when req_ready_o is high
`timescale 1ns/1ps

module trap_ctrl_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid_i,
    input  trap_pkg::trap_req_t       req_i,
    output logic                      req_ready_o,
    input  logic                      hold_i,       // busy atomic op
    input  logic                      ext_irq_i,
    input  logic                      cfg_valid_i,
    input  clint_pkg::cfg_wr_t        cfg_i,
    output logic                      redirect_valid_o,
    output logic [trap_pkg::XLEN-1:0] redirect_pc_o,
    output trap_pkg::csr_view_t       csr_o
);

    logic                 timer_irq;
    logic                 soft_irq;
    logic                 take;
    logic                 accept;
    trap_pkg::trap_info_t info;
    trap_pkg::csr_wr_t    csr_wr;
    trap_pkg::csr_view_t  view;

    clint_timer clint_timer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_valid_i(cfg_valid_i),
        .cfg_i      (cfg_i),
        .timer_irq_o(timer_irq),
        .soft_irq_o (soft_irq)
    );

    trap_select trap_select_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid_i(req_valid_i),
        .req_i      (req_i),
        .accept_i   (accept),
        .ext_irq_i  (ext_irq_i),
        .timer_irq_i(timer_irq),
        .soft_irq_i (soft_irq),
        .view_i     (view),
        .take_o     (take),
        .info_o     (info)
    );

    trap_fsm trap_fsm_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid_i     (req_valid_i),
        .take_i          (take),
        .hold_i          (hold_i),
        .info_i          (info),
        .view_i          (view),
        .req_ready_o     (req_ready_o),
        .accept_o        (accept),
        .csr_wr_o        (csr_wr),
        .redirect_valid_o(redirect_valid_o),
        .redirect_pc_o   (redirect_pc_o)
    );

    mcsr_file mcsr_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_wr_i   (csr_wr),
        .cfg_valid_i(cfg_valid_i),
        .cfg_i      (cfg_i),
        .view_o     (view)
    );

    assign csr_o = view;

endmodule

// File: logic/mcsr_file.sv
// no read port; trap FSM write wins over a configuration write to the same CSR
`timescale 1ns/1ps

module mcsr_file (
    input  logic                clk,
    input  logic                rst_n,
    input  trap_pkg::csr_wr_t   csr_wr_i,
    input  logic                cfg_valid_i,
    input  clint_pkg::cfg_wr_t  cfg_i,
    output trap_pkg::csr_view_t view_o
);

    trap_pkg::csr_view_t view_q;

    // next value of one CSR given its address and current contents
    function automatic logic [trap_pkg::XLEN-1:0] next_csr(
        input logic [11:0]               addr,
        input logic [trap_pkg::XLEN-1:0] cur
    );
        logic [trap_pkg::XLEN-1:0] val;
        val = cur;
        if (csr_wr_i.we && (csr_wr_i.addr == addr)) begin
            val = csr_wr_i.data;
        end else if (cfg_valid_i && (cfg_i.addr == addr)) begin
            val = cfg_i.data;
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            view_q <= '0;
        end else begin
            view_q.mstatus <= next_csr(trap_pkg::CSR_MSTATUS, view_q.mstatus);
            view_q.mie     <= next_csr(trap_pkg::CSR_MIE, view_q.mie);
            view_q.mtvec   <= next_csr(trap_pkg::CSR_MTVEC, view_q.mtvec);
            view_q.mepc    <= next_csr(trap_pkg::CSR_MEPC, view_q.mepc);
            view_q.mcause  <= next_csr(trap_pkg::CSR_MCAUSE, view_q.mcause);
            view_q.mtval   <= next_csr(trap_pkg::CSR_MTVAL, view_q.mtval);
        end
    end

    assign view_o = view_q; // writes show up the cycle after they are issued

endmodule

// File: logic/trap_fsm.sv
// one CSR write per cycle after PENDING; hold_i only stalls the PENDING exit
`timescale 1ns/1ps

module trap_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid_i,
    input  logic                          take_i,
    input  logic                          hold_i,
    input  trap_pkg::trap_info_t          info_i,
    input  trap_pkg::csr_view_t           view_i,
    output logic                          req_ready_o,
    output logic                          accept_o,
    output trap_pkg::csr_wr_t             csr_wr_o,
    output logic                          redirect_valid_o,
    output logic [trap_pkg::XLEN-1:0]     redirect_pc_o
);

    trap_pkg::trap_state_e         state_q;
    trap_pkg::trap_state_e         state_d;
    logic                          leave_pend;
    logic [trap_pkg::XLEN-1:0]     vec_base;
    logic [trap_pkg::XLEN-1:0]     trap_target;
    logic [trap_pkg::XLEN-1:0]     mstatus_trap;
    logic [trap_pkg::XLEN-1:0]     mstatus_mret;
    logic                          redir_q;
    logic [trap_pkg::XLEN-1:0]     redir_pc_q;

    assign req_ready_o = (state_q == trap_pkg::IDLE);
    assign accept_o    = req_valid_i & req_ready_o;
    assign leave_pend  = (state_q == trap_pkg::PENDING) && !hold_i;

    // vectored mode applies to interrupts only with 4 bytes per cause
    assign vec_base    = {view_i.mtvec[trap_pkg::XLEN-1:2], 2'b00};
    assign trap_target = (info_i.is_int && view_i.mtvec[0]) ?
                         vec_base + {info_i.cause[trap_pkg::XLEN-3:0], 2'b00} : vec_base;

    always_comb begin
        mstatus_trap                 = view_i.mstatus;
        mstatus_trap[trap_pkg::MPIE] = view_i.mstatus[trap_pkg::MIE];
        mstatus_trap[trap_pkg::MIE]  = 1'b0; // interrupts off in the handler
        mstatus_mret                 = view_i.mstatus;
        mstatus_mret[trap_pkg::MIE]  = view_i.mstatus[trap_pkg::MPIE];
        mstatus_mret[trap_pkg::MPIE] = 1'b1;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            trap_pkg::IDLE: begin
                if (accept_o && take_i) state_d = trap_pkg::PENDING;
            end
            trap_pkg::PENDING: begin
                if (!hold_i) begin
                    state_d = info_i.is_mret ? trap_pkg::W_MSTATUS : trap_pkg::W_MEPC;
                end
            end
            trap_pkg::W_MEPC:    state_d = trap_pkg::W_MSTATUS;
            trap_pkg::W_MSTATUS: state_d = info_i.is_mret ? trap_pkg::IDLE : trap_pkg::W_MTVAL;
            trap_pkg::W_MTVAL:   state_d = trap_pkg::W_MCAUSE;
            default:             state_d = trap_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= trap_pkg::IDLE;
            redir_q <= 1'b0;
        end else begin
            state_q <= state_d;
            redir_q <= leave_pend; // single pulse as PENDING is left once
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redir_pc_q <= '0;
        end else if (leave_pend) begin
            redir_pc_q <= info_i.is_mret ? view_i.mepc : trap_target;
        end
    end

    // write port follows the state directly
    always_comb begin
        csr_wr_o = '0;
        case (state_q)
            trap_pkg::W_MEPC: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = trap_pkg::CSR_MEPC;
                csr_wr_o.data = info_i.epc;
            end
            trap_pkg::W_MSTATUS: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = trap_pkg::CSR_MSTATUS;
                csr_wr_o.data = info_i.is_mret ? mstatus_mret : mstatus_trap;
            end
            trap_pkg::W_MTVAL: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = trap_pkg::CSR_MTVAL;
                csr_wr_o.data = info_i.tval;
            end
            trap_pkg::W_MCAUSE: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = trap_pkg::CSR_MCAUSE;
                csr_wr_o.data = info_i.cause;
            end
            default: csr_wr_o = '0;
        endcase
    end

    assign redirect_valid_o = redir_q;
    assign redirect_pc_o    = redir_pc_q;

endmodule

// File: logic/trap_select.sv
// take_o is combinational from the live request; info_o holds the last accepted trap
`timescale 1ns/1ps

module trap_select (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid_i,
    input  trap_pkg::trap_req_t  req_i,
    input  logic                 accept_i,
    input  logic                 ext_irq_i,
    input  logic                 timer_irq_i,
    input  logic                 soft_irq_i,
    input  trap_pkg::csr_view_t  view_i,
    output logic                 take_o,
    output trap_pkg::trap_info_t info_o
);

    logic                 glb_en;
    logic                 ext_en;
    logic                 tmr_en;
    logic                 sw_en;
    logic                 int_pend;
    trap_pkg::trap_info_t info_d;
    trap_pkg::trap_info_t info_q;

    assign glb_en = view_i.mstatus[trap_pkg::MIE];
    assign ext_en = ext_irq_i & view_i.mie[trap_pkg::MEIE] & glb_en;
    assign tmr_en = timer_irq_i & view_i.mie[trap_pkg::MTIE] & glb_en;
    assign sw_en  = soft_irq_i & view_i.mie[trap_pkg::MSIE] & glb_en;

    assign int_pend = ext_en | tmr_en | sw_en;
    assign take_o   = req_valid_i & ((req_i.kind != trap_pkg::NONE) | int_pend);

    // exception > mret > external > timer > software
    always_comb begin
        info_d         = '0;
        info_d.epc     = req_i.pc;
        info_d.is_mret = (req_i.kind == trap_pkg::MRET);
        case (req_i.kind)
            trap_pkg::ECALL:  info_d.cause = trap_pkg::CAUSE_ECALL;
            trap_pkg::EBREAK: info_d.cause = trap_pkg::CAUSE_EBREAK;
            trap_pkg::ILLEGAL: begin
                info_d.cause = trap_pkg::CAUSE_ILLEGAL;
                info_d.tval  = req_i.inst; // offending instruction word
            end
            trap_pkg::MIS_FETCH: begin
                info_d.cause = trap_pkg::CAUSE_MIS_FETCH;
                info_d.tval  = req_i.pc;
            end
            trap_pkg::MIS_LOAD: begin
                info_d.cause = trap_pkg::CAUSE_MIS_LOAD;
                info_d.tval  = req_i.next_pc; // core puts the data address here
            end
            trap_pkg::MIS_STORE: begin
                info_d.cause = trap_pkg::CAUSE_MIS_STORE;
                info_d.tval  = req_i.next_pc;
            end
            trap_pkg::MRET: info_d.cause = '0; // target comes from mepc
            default: begin
                // plain instruction, only an interrupt can trap here
                info_d.is_int = 1'b1;
                info_d.epc    = req_i.next_pc; // resume after the retiring instruction
                if (ext_en) begin
                    info_d.cause = trap_pkg::CAUSE_INT_EXT;
                end else if (tmr_en) begin
                    info_d.cause = trap_pkg::CAUSE_INT_TIMER;
                end else begin
                    info_d.cause = trap_pkg::CAUSE_INT_SOFT;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            info_q <= '0;
        end else if (accept_i && take_o) begin
            info_q <= info_d;
        end
    end

    assign info_o = info_q;

endmodule

// File: logic/clint_timer.sv
// timer_irq_o lags the mtime >= mtimecmp compare by one cycle; msip is bit 0 of its word
`timescale 1ns/1ps

module clint_timer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_valid_i,
    input  clint_pkg::cfg_wr_t cfg_i,
    output logic               timer_irq_o,
    output logic               soft_irq_o
);

    logic [clint_pkg::TIMER_W-1:0] mtime_q;
    logic [clint_pkg::TIMER_W-1:0] mtimecmp_q;
    logic                          msip_q;
    logic                          timer_irq_q;
    logic                          cmp_we;
    logic                          msip_we;

    // address decode for the timer region
    assign cmp_we  = cfg_valid_i && (cfg_i.addr == clint_pkg::MTIMECMP_ADDR);
    assign msip_we = cfg_valid_i && (cfg_i.addr == clint_pkg::MSIP_ADDR);

    // free running, wraps at 2^32
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= clint_pkg::MTIMECMP_RST;
            msip_q     <= 1'b0;
        end else begin
            if (cmp_we) begin
                mtimecmp_q <= cfg_i.data[clint_pkg::TIMER_W-1:0];
            end
            if (msip_we) begin
                msip_q <= cfg_i.data[0];
            end
        end
    end

    // registered compare keeps the adder off the trap decision path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq_q <= 1'b0;
        end else begin
            timer_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign timer_irq_o = timer_irq_q;
    assign soft_irq_o  = msip_q;

endmodule

// File: logic/clint_pkg.sv
// write-only configuration bus, one cycle per write; mtime is 32 bits and wraps
package clint_pkg;

    localparam int CFG_AW  = 12;
    localparam int TIMER_W = 32;

    // timer region, the CSR region reuses the trap_pkg addresses
    localparam logic [CFG_AW-1:0] MTIMECMP_ADDR = 12'h800;
    localparam logic [CFG_AW-1:0] MSIP_ADDR     = 12'h804;

    // no timer interrupt until software programs a compare value
    localparam logic [TIMER_W-1:0] MTIMECMP_RST = '1;

    typedef struct packed {
        logic [CFG_AW-1:0]        addr;
        logic [trap_pkg::XLEN-1:0] data;
    } cfg_wr_t;

endpackage

// File: logic/trap_pkg.sv
// machine mode only, no delegation or nesting; csr_view_t carries mie as a sixth word
package trap_pkg;

    localparam int XLEN = 32;

    // request kind offered by the core at an instruction boundary
    typedef enum logic [2:0] {
        NONE,
        ECALL,
        EBREAK,
        ILLEGAL,
        MIS_FETCH,
        MIS_LOAD,
        MIS_STORE,
        MRET
    } exc_e;

    typedef enum logic [5:0] {
        IDLE      = 6'b000001,
        PENDING   = 6'b000010,
        W_MEPC    = 6'b000100,
        W_MSTATUS = 6'b001000,
        W_MTVAL   = 6'b010000,
        W_MCAUSE  = 6'b100000
    } trap_state_e;

    // synchronous exception codes
    localparam logic [XLEN-1:0] CAUSE_MIS_FETCH = 32'd0;
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL   = 32'd2;
    localparam logic [XLEN-1:0] CAUSE_EBREAK    = 32'd3;
    localparam logic [XLEN-1:0] CAUSE_MIS_LOAD  = 32'd4;
    localparam logic [XLEN-1:0] CAUSE_MIS_STORE = 32'd6;
    localparam logic [XLEN-1:0] CAUSE_ECALL     = 32'd11;
    // interrupt codes, top bit marks an interrupt
    localparam logic [XLEN-1:0] CAUSE_INT_EXT   = 32'h8000_000b;
    localparam logic [XLEN-1:0] CAUSE_INT_TIMER = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_INT_SOFT  = 32'h8000_0003;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MTVAL   = 12'h343;

    localparam int MIE  = 3;  // mstatus bits
    localparam int MPIE = 7;
    localparam int MEIE = 11; // mie bits
    localparam int MTIE = 7;
    localparam int MSIE = 3;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next_pc; // already resolved by the core, taken jumps included
        logic [XLEN-1:0] inst;
        exc_e            kind;
    } trap_req_t;

    typedef struct packed {
        logic            we;
        logic [11:0]     addr;
        logic [XLEN-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic [XLEN-1:0] mstatus;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
    } csr_view_t;

    typedef struct packed {
        logic            is_mret;
        logic            is_int;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] epc;
        logic [XLEN-1:0] tval;
    } trap_info_t;

endpackage
